// ==== all.f ====
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f all.f --top-module tb_rv_core -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  exit 1
fi
exit 0

// ==== tb_rv_core.sv ====
/* testbench for the multi-cycle RV32I core that builds a program in the
   instruction memory, models both memories and checks stores, timing and halt */
`include "rv_settings.svh"

module tb_rv_core;

  logic clk;
  logic rst;
  logic [`RV_XLEN-1:0] i_insn;
  logic [`RV_XLEN-1:0] i_dmem_rdata;
  logic [`RV_XLEN-1:0] o_pc;
  logic [`RV_XLEN-1:0] o_dmem_addr;
  logic [`RV_XLEN-1:0] o_dmem_wdata;
  logic o_dmem_we;
  logic o_halt;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] lfsr;
  logic [31:0] bpc;
  logic [31:0] slot;
  logic [31:0] exp_addr [$];
  logic [31:0] exp_val [$];
  int exp_test [$];
  int errs [6];
  string names [6] = '{"reset", "alu", "upper_jump", "branch", "store_timing", "halt"};
  int cyc;
  int limit;
  int n_insn;
  logic [31:0] ecall_pc;
  logic started;
  logic halted;
  logic reset_seen;
  logic [31:0] prev_pc;
  logic [31:0] halt_pc;
  int cnt;
  int we_cnt;

  rv_core dut_i (
    .clk          (clk),
    .rst          (rst),
    .i_insn       (i_insn),
    .i_dmem_rdata (i_dmem_rdata),
    .o_pc         (o_pc),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_halt       (o_halt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic [31:0] lfsr_step(input [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return r;
  endfunction

  // instruction encoders for the RV32I formats
  function automatic [31:0] enc_r(input [6:0] f7, input [4:0] rs2, input [4:0] rs1,
                                  input [2:0] f3, input [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic [31:0] enc_i(input [11:0] imm, input [4:0] rs1, input [2:0] f3,
                                  input [4:0] rd, input [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic [31:0] enc_s(input [11:0] imm, input [4:0] rs2, input [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic [31:0] enc_b(input [12:0] imm, input [4:0] rs2, input [4:0] rs1,
                                  input [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic [31:0] enc_j(input [20:0] imm, input [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // expected branch outcome by funct3
  function automatic logic branch_ref(input [2:0] f3, input [31:0] a, input [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return !($signed(a) < $signed(b));
      3'b110:  return a < b;
      default: return !(a < b);
    endcase
  endfunction

  task automatic emit(input [31:0] w);
    imem[bpc[9:2]] = w;
    bpc = bpc + 4;
    n_insn++;
  endtask

  // sw rs to the next result slot and remember what must land there
  // x6 holds 1 so each store address is one byte past its slot
  task automatic store_expect(input [4:0] rs, input [31:0] val, input int t);
    emit(enc_s(slot[11:0], rs, 5'd6));
    exp_addr.push_back(slot);
    exp_val.push_back(val);
    exp_test.push_back(t);
    slot = slot + 4;
  endtask

  task automatic check_val(input int t, input [31:0] exp, input [31:0] act);
    assert (exp == act) else begin
      errs[t]++;
      $display("FAIL %s expected %h actual %h", names[t], exp, act);
    end
  endtask

  task automatic build_program(input [31:0] a, input [31:0] b);
    logic [11:0] imm;
    logic [31:0] simm;
    logic [4:0] sh;
    logic [31:0] p;
    logic [31:0] r;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [2:0] fl [6];
    fl = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    emit(enc_i(12'd0, 5'd0, 3'b010, 5'd1, 7'h03));
    emit(enc_i(12'd4, 5'd0, 3'b010, 5'd2, 7'h03));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd6, 7'h13));
    emit(enc_i(12'd2, 5'd0, 3'b000, 5'd7, 7'h13));
    // register-register ops into x3
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    store_expect(5'd3, a + b, 1);
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
    store_expect(5'd3, a - b, 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3));
    store_expect(5'd3, a << b[4:0], 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3));
    store_expect(5'd3, {31'd0, $signed(a) < $signed(b)}, 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd3));
    store_expect(5'd3, {31'd0, a < b}, 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3));
    store_expect(5'd3, a ^ b, 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd3));
    store_expect(5'd3, a >> b[4:0], 1);
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3));
    store_expect(5'd3, $unsigned($signed(a) >>> b[4:0]), 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3));
    store_expect(5'd3, a | b, 1);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3));
    store_expect(5'd3, a & b, 1);
    // a write to x0 must read back as zero
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    store_expect(5'd0, 32'd0, 1);
    // register-immediate ops with random immediates
    r = rand_bits(12);
    imm = r[11:0];
    simm = {{20{imm[11]}}, imm};
    emit(enc_i(imm, 5'd1, 3'b000, 5'd3, 7'h13));
    store_expect(5'd3, a + simm, 1);
    emit(enc_i(imm, 5'd1, 3'b010, 5'd3, 7'h13));
    store_expect(5'd3, {31'd0, $signed(a) < $signed(simm)}, 1);
    emit(enc_i(imm, 5'd1, 3'b011, 5'd3, 7'h13));
    store_expect(5'd3, {31'd0, a < simm}, 1);
    emit(enc_i(imm, 5'd1, 3'b100, 5'd3, 7'h13));
    store_expect(5'd3, a ^ simm, 1);
    emit(enc_i(imm, 5'd1, 3'b110, 5'd3, 7'h13));
    store_expect(5'd3, a | simm, 1);
    emit(enc_i(imm, 5'd1, 3'b111, 5'd3, 7'h13));
    store_expect(5'd3, a & simm, 1);
    r = rand_bits(5);
    sh = r[4:0];
    emit(enc_i({7'h00, sh}, 5'd1, 3'b001, 5'd3, 7'h13));
    store_expect(5'd3, a << sh, 1);
    emit(enc_i({7'h00, sh}, 5'd1, 3'b101, 5'd3, 7'h13));
    store_expect(5'd3, a >> sh, 1);
    emit(enc_i({7'h20, sh}, 5'd1, 3'b101, 5'd3, 7'h13));
    store_expect(5'd3, $unsigned($signed(a) >>> sh), 1);
    // lui and auipc
    emit({20'h12345, 5'd3, 7'h37});
    store_expect(5'd3, 32'h1234_5000, 2);
    p = bpc;
    emit({20'habcde, 5'd3, 7'h17});
    store_expect(5'd3, p + 32'habcd_e000, 2);
    // jal skips one marker store
    p = bpc;
    emit(enc_j(21'd8, 5'd4));
    store_expect(5'd7, 32'd0, 2);
    store_expect(5'd4, p + 4, 2);
    // jalr target has bit 0 set, which the core clears
    p = bpc;
    emit(enc_i(p[11:0] + 12'd13, 5'd0, 3'b000, 5'd8, 7'h13));
    emit(enc_i(12'd0, 5'd8, 3'b000, 5'd4, 7'h67));
    store_expect(5'd7, 32'd0, 2);
    store_expect(5'd4, p + 8, 2);
    // each branch over pairs (a,a), (a,b), (b,a)
    for (int f = 0; f < 6; f++) begin
      for (int k = 0; k < 3; k++) begin
        ra = (k == 2) ? 5'd2 : 5'd1;
        rb = (k == 1) ? 5'd2 : 5'd1;
        emit(enc_b(13'd8, rb, ra, fl[f]));
        store_expect(5'd7, branch_ref(fl[f], (ra == 5'd1) ? a : b, (rb == 5'd1) ? a : b)
                     ? 32'd0 : 32'd2, 3);
        store_expect(5'd6, 32'd1, 3);
      end
    end
    ecall_pc = bpc;
    emit(32'h0000_0073);
    // never reached once halted
    store_expect(5'd6, 32'd0, 5);
  endtask

  // memory models answer one cycle after sampling the address
  always @(posedge clk) begin
    i_insn <= imem[o_pc[9:2]];
    i_dmem_rdata <= dmem[o_dmem_addr[9:2]];
    if (o_dmem_we) begin
      dmem[o_dmem_addr[9:2]] <= o_dmem_wdata;
    end
  end

  // cycle counter and timeout
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > limit) begin
      $display("timeout: core did not halt within %0d cycles", limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // reset, timing, store strobe and halt monitor
  always @(posedge clk) begin
    // the first edge is the one that applies the synchronous reset
    if (cyc != 0 && (rst || !reset_seen)) begin
      check_val(0, 32'd0, o_pc);
      check_val(0, 32'd0, {30'd0, o_halt, o_dmem_we});
      if (!rst) begin
        reset_seen <= 1'b1;
        $display("test %s: %s", names[0], (errs[0] == 0) ? "ok" : "FAIL");
      end
    end
    if (!rst && o_dmem_we) begin
      check_val(4, 32'd0, {30'd0, o_dmem_addr[1:0]});
    end
    if (!rst && !o_halt && !halted) begin
      if (!started || o_pc != prev_pc) begin
        if (started) begin
          check_val(4, (imem[prev_pc[9:2]][6:0] == 7'h03) ? 3 : 2, cnt);
          check_val(4, (imem[prev_pc[9:2]][6:0] == 7'h23) ? 1 : 0, we_cnt);
        end
        started <= 1'b1;
        prev_pc <= o_pc;
        cnt <= 1;
        we_cnt <= int'(o_dmem_we);
      end else begin
        cnt <= cnt + 1;
        we_cnt <= we_cnt + int'(o_dmem_we);
      end
    end
    if (!rst && o_halt && !halted) begin
      halted <= 1'b1;
      halt_pc <= o_pc;
      // ECALL retires in its execute cycle, so the PC has moved past it
      check_val(5, ecall_pc + 32'd4, o_pc);
    end
    if (halted) begin
      assert (o_halt) else begin
        errs[5]++;
        $display("halt dropped after ECALL");
      end
      assert (!o_dmem_we) else begin
        errs[5]++;
        $display("store issued after halt");
      end
      check_val(5, halt_pc, o_pc);
    end
  end

  initial begin
    int fails;
    int failed_tests;
    rst = 1'b1;
    i_insn = '0;
    i_dmem_rdata = '0;
    cyc = 0;
    n_insn = 0;
    limit = 100000;
    started = 1'b0;
    halted = 1'b0;
    reset_seen = 1'b0;
    prev_pc = '0;
    halt_pc = '0;
    cnt = 0;
    we_cnt = 0;
    lfsr = 32'hc7a8_9965;
    bpc = 32'h0;
    slot = 32'h40;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    dmem[0] = rand_bits(32);
    dmem[1] = rand_bits(32);
    build_program(dmem[0], dmem[1]);
    limit = 16 + 3 * n_insn + 64;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    wait (halted);
    repeat (20) @(posedge clk);
    for (int i = 0; i < exp_addr.size(); i++) begin
      check_val(exp_test[i], exp_val[i], dmem[exp_addr[i][9:2]]);
    end
    fails = 0;
    failed_tests = 0;
    for (int t = 1; t < 6; t++) begin
      $display("test %s: %s", names[t], (errs[t] == 0) ? "ok" : "FAIL");
    end
    for (int t = 0; t < 6; t++) begin
      fails += errs[t];
      failed_tests += (errs[t] != 0) ? 1 : 0;
    end
    $display("tests run 6, tests failed %0d, failed checks %0d", failed_tests, fails);
    if (fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== rv_core.sv ====
/* multi-cycle RV32I core top level
   instruction and data ports answer one cycle after the address is sampled */
`include "rv_settings.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,
  input  logic [`RV_XLEN-1:0] i_insn,
  input  logic [`RV_XLEN-1:0] i_dmem_rdata,
  output logic [`RV_XLEN-1:0] o_pc,
  output logic [`RV_XLEN-1:0] o_dmem_addr,
  output logic [`RV_XLEN-1:0] o_dmem_wdata,
  output logic                o_dmem_we,
  output logic                o_halt
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] next_pc;
  logic exec;
  logic retire;

  logic [`RV_REG_IDX_W-1:0] rs1;
  logic [`RV_REG_IDX_W-1:0] rs2;
  logic [`RV_REG_IDX_W-1:0] rd;
  logic [`RV_XLEN-1:0] imm;
  alu_op_e alu_op;
  logic use_imm;
  logic use_pc;
  logic is_branch;
  logic is_jump;
  logic is_jalr;
  logic [2:0] branch_funct;
  logic is_load;
  logic is_store;
  logic is_ecall;
  logic rd_write;
  wb_sel_e wb_sel;

  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] result;
  logic rf_we;
  logic [`RV_XLEN-1:0] rf_wdata;

  rv_fetch fetch_i (
    .clk        (clk),
    .rst        (rst),
    .i_next_pc  (next_pc),
    .i_is_load  (is_load),
    .i_is_ecall (is_ecall),
    .o_pc       (o_pc),
    .o_exec     (exec),
    .o_retire   (retire),
    .o_halt     (o_halt)
  );

  rv_decode decode_i (
    .i_insn         (i_insn),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (rd),
    .o_imm          (imm),
    .o_alu_op       (alu_op),
    .o_use_imm      (use_imm),
    .o_use_pc       (use_pc),
    .o_is_branch    (is_branch),
    .o_is_jump      (is_jump),
    .o_is_jalr      (is_jalr),
    .o_branch_funct (branch_funct),
    .o_is_load      (is_load),
    .o_is_store     (is_store),
    .o_is_ecall     (is_ecall),
    .o_rd_write     (rd_write),
    .o_wb_sel       (wb_sel)
  );

  rv_regfile regfile_i (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (rd),
    .i_we       (rf_we),
    .i_wdata    (rf_wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_alu alu_i (
    .i_pc           (o_pc),
    .i_rs1_data     (rs1_data),
    .i_rs2_data     (rs2_data),
    .i_imm          (imm),
    .i_alu_op       (alu_op),
    .i_use_imm      (use_imm),
    .i_use_pc       (use_pc),
    .i_is_branch    (is_branch),
    .i_is_jump      (is_jump),
    .i_is_jalr      (is_jalr),
    .i_branch_funct (branch_funct),
    .o_result       (result),
    .o_next_pc      (next_pc)
  );

  rv_lsu lsu_i (
    .i_exec       (exec),
    .i_retire     (retire),
    .i_is_store   (is_store),
    .i_rd_write   (rd_write),
    .i_wb_sel     (wb_sel),
    .i_result     (result),
    .i_pc         (o_pc),
    .i_rs2_data   (rs2_data),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_rf_we      (rf_we),
    .o_rf_wdata   (rf_wdata)
  );

endmodule

// ==== rv_lsu.sv ====
/* data port drive for word loads and stores, and the register
   writeback mux with its enable */
`include "rv_settings.svh"

module rv_lsu (
  input  logic                i_exec,
  input  logic                i_retire,
  input  logic                i_is_store,
  input  logic                i_rd_write,
  input  rv_pkg::wb_sel_e     i_wb_sel,
  input  logic [`RV_XLEN-1:0] i_result,
  input  logic [`RV_XLEN-1:0] i_pc,
  input  logic [`RV_XLEN-1:0] i_rs2_data,
  input  logic [`RV_XLEN-1:0] i_dmem_rdata,
  output logic [`RV_XLEN-1:0] o_dmem_addr,
  output logic [`RV_XLEN-1:0] o_dmem_wdata,
  output logic                o_dmem_we,
  output logic                o_rf_we,
  output logic [`RV_XLEN-1:0] o_rf_wdata
);
  import rv_pkg::*;

  // word accesses only, the low address bits are dropped
  assign o_dmem_addr  = {i_result[`RV_XLEN-1:2], 2'b00};
  assign o_dmem_wdata = i_rs2_data;
  // one write strobe, in the execute cycle of a store
  assign o_dmem_we    = i_exec && i_is_store;

  assign o_rf_we = i_retire && i_rd_write;

  always_comb begin
    case (i_wb_sel)
      WB_PC4:  o_rf_wdata = i_pc + 32'd4;
      WB_LOAD: o_rf_wdata = i_dmem_rdata;
      default: o_rf_wdata = i_result;
    endcase
  end

endmodule

// ==== rv_alu.sv ====
/* integer ALU with branch compare and next-PC selection
   purely combinational, evaluated in the execute cycle */
`include "rv_settings.svh"

module rv_alu (
  input  logic [`RV_XLEN-1:0] i_pc,
  input  logic [`RV_XLEN-1:0] i_rs1_data,
  input  logic [`RV_XLEN-1:0] i_rs2_data,
  input  logic [`RV_XLEN-1:0] i_imm,
  input  rv_pkg::alu_op_e     i_alu_op,
  input  logic                i_use_imm,
  input  logic                i_use_pc,
  input  logic                i_is_branch,
  input  logic                i_is_jump,
  input  logic                i_is_jalr,
  input  logic [2:0]          i_branch_funct,
  output logic [`RV_XLEN-1:0] o_result,
  output logic [`RV_XLEN-1:0] o_next_pc
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [4:0] shamt;
  logic taken;
  logic [`RV_XLEN-1:0] jalr_target;

  assign op_a  = i_use_pc ? i_pc : i_rs1_data;
  assign op_b  = i_use_imm ? i_imm : i_rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_alu_op)
      ALU_ADD:  o_result = op_a + op_b;
      ALU_SUB:  o_result = op_a - op_b;
      ALU_SLL:  o_result = op_a << shamt;
      ALU_SLT:  o_result = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: o_result = {31'd0, op_a < op_b};
      ALU_XOR:  o_result = op_a ^ op_b;
      ALU_SRL:  o_result = op_a >> shamt;
      ALU_SRA:  o_result = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:   o_result = op_a | op_b;
      ALU_AND:  o_result = op_a & op_b;
      default:  o_result = op_b;
    endcase
  end

  // branch condition from funct3, always on the two registers
  always_comb begin
    case (i_branch_funct)
      3'b000:  taken = (i_rs1_data == i_rs2_data);
      3'b001:  taken = (i_rs1_data != i_rs2_data);
      3'b100:  taken = $signed(i_rs1_data) < $signed(i_rs2_data);
      3'b101:  taken = $signed(i_rs1_data) >= $signed(i_rs2_data);
      3'b110:  taken = i_rs1_data < i_rs2_data;
      3'b111:  taken = i_rs1_data >= i_rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_target = i_rs1_data + i_imm;

  always_comb begin
    if (i_is_jalr) begin
      o_next_pc = {jalr_target[`RV_XLEN-1:1], 1'b0};
    end else if (i_is_jump || (i_is_branch && taken)) begin
      o_next_pc = i_pc + i_imm;
    end else begin
      o_next_pc = i_pc + 32'd4;
    end
  end

endmodule

// ==== rv_regfile.sv ====
/* integer register file, two combinational read ports and one write port
   x0 always reads as zero */
`include "rv_settings.svh"

module rv_regfile (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`RV_REG_IDX_W-1:0] i_rs1,
  input  logic [`RV_REG_IDX_W-1:0] i_rs2,
  input  logic [`RV_REG_IDX_W-1:0] i_rd,
  input  logic                     i_we,
  input  logic [`RV_XLEN-1:0]      i_wdata,
  output logic [`RV_XLEN-1:0]      o_rs1_data,
  output logic [`RV_XLEN-1:0]      o_rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // x0 is cleared by reset and never written afterwards
  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

endmodule

// ==== rv_decode.sv ====
/* instruction decoder: register indices, immediates, operand and ALU
   selection, and the control flags for branch, memory and writeback */
`include "rv_settings.svh"

module rv_decode (
  input  logic [`RV_XLEN-1:0]      i_insn,
  output logic [`RV_REG_IDX_W-1:0] o_rs1,
  output logic [`RV_REG_IDX_W-1:0] o_rs2,
  output logic [`RV_REG_IDX_W-1:0] o_rd,
  output logic [`RV_XLEN-1:0]      o_imm,
  output rv_pkg::alu_op_e          o_alu_op,
  output logic                     o_use_imm,
  output logic                     o_use_pc,
  output logic                     o_is_branch,
  output logic                     o_is_jump,
  output logic                     o_is_jalr,
  output logic [2:0]               o_branch_funct,
  output logic                     o_is_load,
  output logic                     o_is_store,
  output logic                     o_is_ecall,
  output logic                     o_rd_write,
  output rv_pkg::wb_sel_e          o_wb_sel
);
  import rv_pkg::*;

  opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  alu_op_e funct_op;

  assign opcode = opcode_e'(i_insn[`RV_OPCODE_W-1:0]);
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];
  assign o_rd   = i_insn[11:7];
  assign o_rs1  = i_insn[19:15];
  assign o_rs2  = i_insn[24:20];

  // sign-extended immediates of each format
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

  // funct3 to ALU op, funct7[5] picks sub and sra
  // (sub only exists for register-register)
  always_comb begin
    case (funct3)
      3'b000:  funct_op = (opcode == OP_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  funct_op = ALU_SLL;
      3'b010:  funct_op = ALU_SLT;
      3'b011:  funct_op = ALU_SLTU;
      3'b100:  funct_op = ALU_XOR;
      3'b101:  funct_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  funct_op = ALU_OR;
      default: funct_op = ALU_AND;
    endcase
  end

  always_comb begin
    o_imm      = imm_i;
    o_alu_op   = ALU_ADD;
    o_use_imm  = 1'b0;
    o_use_pc   = 1'b0;
    o_rd_write = 1'b0;
    o_wb_sel   = WB_ALU;
    case (opcode)
      OP_LUI: begin
        o_imm      = imm_u;
        o_alu_op   = ALU_PASS_B;
        o_use_imm  = 1'b1;
        o_rd_write = 1'b1;
      end
      OP_AUIPC: begin
        o_imm      = imm_u;
        o_use_imm  = 1'b1;
        o_use_pc   = 1'b1;
        o_rd_write = 1'b1;
      end
      OP_JAL: begin
        o_imm      = imm_j;
        o_rd_write = 1'b1;
        o_wb_sel   = WB_PC4;
      end
      OP_JALR: begin
        o_rd_write = 1'b1;
        o_wb_sel   = WB_PC4;
      end
      OP_BRANCH: begin
        o_imm = imm_b;
      end
      OP_LOAD: begin
        o_use_imm  = 1'b1;
        o_rd_write = 1'b1;
        o_wb_sel   = WB_LOAD;
      end
      OP_STORE: begin
        o_imm     = imm_s;
        o_use_imm = 1'b1;
      end
      OP_OP_IMM: begin
        o_alu_op   = funct_op;
        o_use_imm  = 1'b1;
        o_rd_write = 1'b1;
      end
      OP_OP: begin
        o_alu_op   = funct_op;
        o_rd_write = 1'b1;
      end
      default: begin
        // fence, csr ops and unknown opcodes change nothing
        o_rd_write = 1'b0;
      end
    endcase
  end

  assign o_is_branch    = (opcode == OP_BRANCH);
  assign o_is_jump      = (opcode == OP_JAL);
  assign o_is_jalr      = (opcode == OP_JALR);
  assign o_branch_funct = funct3;
  // LW only, other load widths are not supported
  assign o_is_load      = (opcode == OP_LOAD) && (funct3 == 3'b010);
  assign o_is_store     = (opcode == OP_STORE) && (funct3 == 3'b010);
  assign o_is_ecall     = (opcode == OP_SYSTEM) && (i_insn[31:7] == 25'd0);

endmodule

// ==== rv_fetch.sv ====
/* instruction sequencer and program counter
   steps fetch, execute and the optional memory cycle, then loads the next PC */
`include "rv_settings.svh"

module rv_fetch (
  input  logic               clk,
  input  logic               rst,
  input  logic [`RV_XLEN-1:0] i_next_pc,
  input  logic               i_is_load,
  input  logic               i_is_ecall,
  output logic [`RV_XLEN-1:0] o_pc,
  output logic               o_exec,
  output logic               o_retire,
  output logic               o_halt
);
  import rv_pkg::*;

  state_e state;
  state_e state_next;
  logic [`RV_XLEN-1:0] pc;

  // the instruction word is valid from S_EXEC on, the memory
  // returns the word one cycle after it samples the PC
  always_comb begin
    state_next = state;
    case (state)
      S_FETCH: begin
        state_next = S_EXEC;
      end
      S_EXEC: begin
        if (i_is_load) begin
          state_next = S_MEM;
        end else if (i_is_ecall) begin
          state_next = S_HALT;
        end else begin
          state_next = S_FETCH;
        end
      end
      S_MEM: begin
        state_next = S_FETCH;
      end
      default: begin
        // S_HALT is terminal until reset
        state_next = S_HALT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_FETCH;
    end else begin
      state <= state_next;
    end
  end

  // loads retire after the data word arrives, everything else in S_EXEC
  assign o_retire = ((state == S_EXEC) && !i_is_load) || (state == S_MEM);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (o_retire) begin
      pc <= i_next_pc;
    end
  end

  assign o_pc   = pc;
  assign o_exec = (state == S_EXEC);
  assign o_halt = (state == S_HALT);

endmodule

// ==== rv_pkg.sv ====
/* types shared by the core: major opcodes, ALU operations, writeback
   sources and the sequencer states */
`include "rv_settings.svh"

package rv_pkg;

  // RV32I major opcodes, insn[6:0]
  typedef enum logic [`RV_OPCODE_W-1:0] {
    OP_LOAD     = 7'b00_000_11,
    OP_MISC_MEM = 7'b00_011_11,
    OP_OP_IMM   = 7'b00_100_11,
    OP_AUIPC    = 7'b00_101_11,
    OP_STORE    = 7'b01_000_11,
    OP_OP       = 7'b01_100_11,
    OP_LUI      = 7'b01_101_11,
    OP_BRANCH   = 7'b11_000_11,
    OP_JALR     = 7'b11_001_11,
    OP_JAL      = 7'b11_011_11,
    OP_SYSTEM   = 7'b11_100_11
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // operand b straight through, used by LUI
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_PC4,
    WB_LOAD
  } wb_sel_e;

  typedef enum logic [1:0] {
    S_FETCH,
    S_EXEC,
    S_MEM,
    S_HALT
  } state_e;

endpackage

// ==== rv_settings.svh ====
/* widths and reset values shared by the core modules and the package
   include this wherever one of the macros is needed */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers x0..x31
`define RV_NUM_REGS 32
`define RV_REG_IDX_W 5

// major opcode field, insn[6:0]
`define RV_OPCODE_W 7

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
